//--- fetch_pkg.sv
// Shared widths and bus structs for a 32-bit core memory side with 1 KiB of word memory
`default_nettype none

package fetch_pkg;

	localparam int XLEN = 32;
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);
	localparam int MEM_BYTES = 4 * MEM_WORDS;	// First byte address that answers with err
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// Bus request shared by reads and writes
	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;
		logic [XLEN/8-1:0] wstrb;
		logic              write;	// Reads ignore wdata and wstrb
	} mem_req_t;

	typedef struct packed {
		logic [XLEN-1:0] rdata;	// Zero for writes
		logic            err;
	} mem_rsp_t;

	// Packet handed to the decoder
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
		logic            fault;
	} fetch_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0] target;
	} redirect_t;

	// External load or store, same layout as a bus request
	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;
		logic [XLEN/8-1:0] wstrb;
		logic              write;
	} lsu_req_t;

endpackage

`default_nettype wire

//--- ifu.sv
// One fetch in flight at a time; a redirect after the request is out lets that fetch finish and discards it
`default_nettype none

module ifu (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fetch_en,
	input  fetch_pkg::redirect_t  redirect,
	input  logic                  redirect_valid,
	output fetch_pkg::mem_req_t   ifu_req,
	output logic                  ifu_req_valid,
	input  logic                  ifu_req_ready,
	input  fetch_pkg::mem_rsp_t   ifu_rsp,
	input  logic                  ifu_rsp_valid,
	output logic                  ifu_rsp_ready,
	output fetch_pkg::fetch_pkt_t inst_pkt,
	output logic                  inst_valid,
	input  logic                  inst_ready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT,
		S_HOLD
	} state_t;

	state_t state;
	logic [fetch_pkg::XLEN-1:0] pc;	// Address being issued or in flight
	logic [fetch_pkg::XLEN-1:0] tgt;	// Latest redirect target
	logic stale;
	logic req_fire;
	logic rsp_fire;
	logic drop_rsp;
	fetch_pkg::fetch_pkt_t pkt_q;

	// In idle the request follows fetch_en directly
	assign ifu_req_valid = (state == S_REQ) || (state == S_IDLE && fetch_en);
	assign ifu_req.addr = pc;
	assign ifu_req.wdata = '0;
	assign ifu_req.wstrb = '0;
	assign ifu_req.write = 1'b0;

	assign ifu_rsp_ready = (state == S_WAIT);
	assign inst_valid = (state == S_HOLD);
	assign inst_pkt = pkt_q;

	assign req_fire = ifu_req_valid && ifu_req_ready;
	assign rsp_fire = ifu_rsp_valid && ifu_rsp_ready;
	assign drop_rsp = stale || redirect_valid;	// Response overtaken by a redirect

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			pc <= fetch_pkg::RESET_PC;
			stale <= 1'b0;
		end else begin
			case (state)
				S_IDLE, S_REQ: begin
					if (req_fire) begin
						state <= S_WAIT;
					end else if (ifu_req_valid) begin
						state <= S_REQ;	// Keep the request up even if fetch_en drops
					end
					if (redirect_valid) begin
						if (ifu_req_valid)
							stale <= 1'b1;	// Address already presented
						else
							pc <= redirect.target;
					end
				end
				S_WAIT: begin
					if (rsp_fire) begin
						if (drop_rsp) begin
							state <= S_IDLE;
							pc <= redirect_valid ? redirect.target : tgt;
							stale <= 1'b0;
						end else begin
							state <= S_HOLD;
						end
					end else if (redirect_valid) begin
						stale <= 1'b1;
					end
				end
				S_HOLD: begin
					if (redirect_valid) begin
						state <= S_IDLE;	// Held packet is dropped
						pc <= redirect.target;
					end else if (inst_ready) begin
						state <= S_IDLE;
						pc <= pc + 32'd4;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_fire && !drop_rsp) begin
			pkt_q.pc <= pc;
			pkt_q.inst <= ifu_rsp.rdata;
			pkt_q.fault <= ifu_rsp.err;	// Out-of-range fetch
		end
		if (redirect_valid)
			tgt <= redirect.target;
	end

	// Decoder sees a steady packet across a stall
	assert property (@(posedge clk) disable iff (rst)
		inst_valid && !inst_ready |=> $stable(inst_pkt));

	// A redirect must not move an address the arbiter has not yet taken
	assert property (@(posedge clk) disable iff (rst)
		ifu_req_valid && !ifu_req_ready |=> ifu_req_valid && $stable(ifu_req));

endmodule

`default_nettype wire

//--- lsu.sv
// One load or store at a time; the low two address bits are cleared and loads return the whole word
`default_nettype none

module lsu (
	input  logic                clk,
	input  logic                rst,
	input  fetch_pkg::lsu_req_t lsu_in,
	input  logic                lsu_in_valid,
	output logic                lsu_in_ready,
	output fetch_pkg::mem_rsp_t lsu_out,
	output logic                lsu_out_valid,
	input  logic                lsu_out_ready,
	output fetch_pkg::mem_req_t lsu_req,
	output logic                lsu_req_valid,
	input  logic                lsu_req_ready,
	input  fetch_pkg::mem_rsp_t lsu_rsp,
	input  logic                lsu_rsp_valid,
	output logic                lsu_rsp_ready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT,
		S_HOLD
	} state_t;

	state_t state;
	fetch_pkg::mem_req_t req_q;
	fetch_pkg::mem_rsp_t rsp_q;

	assign lsu_in_ready = (state == S_IDLE);
	assign lsu_req = req_q;
	assign lsu_req_valid = (state == S_REQ);
	assign lsu_rsp_ready = (state == S_WAIT);
	assign lsu_out = rsp_q;
	assign lsu_out_valid = (state == S_HOLD);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:
					if (lsu_in_valid)
						state <= S_REQ;	// Goes out on the bus next cycle
				S_REQ:
					if (lsu_req_ready)
						state <= S_WAIT;
				S_WAIT:
					if (lsu_rsp_valid)
						state <= S_HOLD;
				S_HOLD:
					if (lsu_out_ready)
						state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lsu_in_valid && lsu_in_ready) begin
			req_q.addr <= {lsu_in.addr[fetch_pkg::XLEN-1:2], 2'b00};	// Word aligned only
			req_q.wdata <= lsu_in.wdata;
			req_q.wstrb <= lsu_in.wstrb;
			req_q.write <= lsu_in.write;
		end
		if (lsu_rsp_valid && lsu_rsp_ready)
			rsp_q <= lsu_rsp;
	end

	// Request stays up until the arbiter takes it
	assert property (@(posedge clk) disable iff (rst)
		lsu_req_valid && !lsu_req_ready |=> lsu_req_valid);

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// Two masters and one memory port; the load/store side wins ties and a grant holds until its response is taken
`default_nettype none

module mem_arbiter (
	input  logic                clk,
	input  logic                rst,
	input  fetch_pkg::mem_req_t ifu_req,
	input  logic                ifu_req_valid,
	output logic                ifu_req_ready,
	output fetch_pkg::mem_rsp_t ifu_rsp,
	output logic                ifu_rsp_valid,
	input  logic                ifu_rsp_ready,
	input  fetch_pkg::mem_req_t lsu_req,
	input  logic                lsu_req_valid,
	output logic                lsu_req_ready,
	output fetch_pkg::mem_rsp_t lsu_rsp,
	output logic                lsu_rsp_valid,
	input  logic                lsu_rsp_ready,
	output fetch_pkg::mem_req_t mem_req,
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	input  fetch_pkg::mem_rsp_t mem_rsp,
	input  logic                mem_rsp_valid,
	output logic                mem_rsp_ready
);

	logic locked;	// A request is out and its response is not yet taken
	logic owner_lsu;
	logic pick_lsu;
	logic req_fire;
	logic rsp_fire;

	// Fixed priority in idle
	assign pick_lsu = lsu_req_valid;

	assign mem_req = pick_lsu ? lsu_req : ifu_req;
	assign mem_req_valid = !locked && (lsu_req_valid || ifu_req_valid);
	assign lsu_req_ready = !locked && mem_req_ready;
	assign ifu_req_ready = !locked && !lsu_req_valid && mem_req_ready;

	// Data goes to both, valid only to the owner
	assign ifu_rsp = mem_rsp;
	assign lsu_rsp = mem_rsp;
	assign ifu_rsp_valid = locked && !owner_lsu && mem_rsp_valid;
	assign lsu_rsp_valid = locked && owner_lsu && mem_rsp_valid;
	assign mem_rsp_ready = locked && (owner_lsu ? lsu_rsp_ready : ifu_rsp_ready);

	assign req_fire = mem_req_valid && mem_req_ready;
	assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			locked <= 1'b0;
			owner_lsu <= 1'b0;
		end else if (req_fire) begin
			locked <= 1'b1;
			owner_lsu <= pick_lsu;
		end else if (rsp_fire) begin
			locked <= 1'b0;	// Port is free again next cycle
		end
	end

	// Memory only answers a request this arbiter passed on
	assert property (@(posedge clk) disable iff (rst)
		mem_rsp_valid |-> locked);

	assert property (@(posedge clk) disable iff (rst)
		!(ifu_rsp_valid && lsu_rsp_valid));

endmodule

`default_nettype wire

//--- sram_model.sv
// Word memory with byte strobes and one response in flight; contents are undefined until written
`default_nettype none

module sram_model (
	input  logic                clk,
	input  logic                rst,
	input  fetch_pkg::mem_req_t mem_req,
	input  logic                mem_req_valid,
	output logic                mem_req_ready,
	output fetch_pkg::mem_rsp_t mem_rsp,
	output logic                mem_rsp_valid,
	input  logic                mem_rsp_ready
);

	logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::MEM_WORDS];
	logic [fetch_pkg::MEM_IDX_W-1:0] idx;
	logic in_range;
	logic req_fire;
	logic rsp_valid_q;
	fetch_pkg::mem_rsp_t rsp_q;

	assign idx = mem_req.addr[fetch_pkg::MEM_IDX_W+1:2];
	assign in_range = (mem_req.addr < fetch_pkg::XLEN'(fetch_pkg::MEM_BYTES));

	// Accept only when nothing is waiting to be returned
	assign mem_req_ready = !rsp_valid_q;
	assign req_fire = mem_req_valid && mem_req_ready;

	assign mem_rsp = rsp_q;
	assign mem_rsp_valid = rsp_valid_q;

	always_ff @(posedge clk) begin
		if (rst)
			rsp_valid_q <= 1'b0;
		else if (req_fire)
			rsp_valid_q <= 1'b1;
		else if (mem_rsp_ready)
			rsp_valid_q <= 1'b0;	// Held until taken
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			rsp_q.err <= !in_range;
			if (mem_req.write || !in_range)
				rsp_q.rdata <= '0;
			else
				rsp_q.rdata <= mem[idx];
			// Only strobed lanes change
			if (mem_req.write && in_range) begin
				for (int b = 0; b < fetch_pkg::XLEN / 8; b++) begin
					if (mem_req.wstrb[b])
						mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- core_mem_top.sv
// Fetch and load/store masters sharing one memory port; no caches and one transaction per master
`default_nettype none

module core_mem_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fetch_en,
	input  fetch_pkg::redirect_t  redirect,
	input  logic                  redirect_valid,
	output fetch_pkg::fetch_pkt_t inst_pkt,
	output logic                  inst_valid,
	input  logic                  inst_ready,
	input  fetch_pkg::lsu_req_t   lsu_in,
	input  logic                  lsu_in_valid,
	output logic                  lsu_in_ready,
	output fetch_pkg::mem_rsp_t   lsu_out,
	output logic                  lsu_out_valid,
	input  logic                  lsu_out_ready
);

	fetch_pkg::mem_req_t ifu_req;
	logic ifu_req_valid;
	logic ifu_req_ready;
	fetch_pkg::mem_rsp_t ifu_rsp;
	logic ifu_rsp_valid;
	logic ifu_rsp_ready;

	fetch_pkg::mem_req_t lsu_req;
	logic lsu_req_valid;
	logic lsu_req_ready;
	fetch_pkg::mem_rsp_t lsu_rsp;
	logic lsu_rsp_valid;
	logic lsu_rsp_ready;

	// Arbiter to memory
	fetch_pkg::mem_req_t mem_req;
	logic mem_req_valid;
	logic mem_req_ready;
	fetch_pkg::mem_rsp_t mem_rsp;
	logic mem_rsp_valid;
	logic mem_rsp_ready;

	ifu ifu_inst (
		.clk, .rst, .fetch_en, .redirect, .redirect_valid,
		.ifu_req, .ifu_req_valid, .ifu_req_ready,
		.ifu_rsp, .ifu_rsp_valid, .ifu_rsp_ready,
		.inst_pkt, .inst_valid, .inst_ready
	);

	lsu lsu_inst (
		.clk, .rst, .lsu_in, .lsu_in_valid, .lsu_in_ready,
		.lsu_out, .lsu_out_valid, .lsu_out_ready,
		.lsu_req, .lsu_req_valid, .lsu_req_ready,
		.lsu_rsp, .lsu_rsp_valid, .lsu_rsp_ready
	);

	mem_arbiter mem_arbiter_inst (
		.clk, .rst,
		.ifu_req, .ifu_req_valid, .ifu_req_ready, .ifu_rsp, .ifu_rsp_valid, .ifu_rsp_ready,
		.lsu_req, .lsu_req_valid, .lsu_req_ready, .lsu_rsp, .lsu_rsp_valid, .lsu_rsp_ready,
		.mem_req, .mem_req_valid, .mem_req_ready, .mem_rsp, .mem_rsp_valid, .mem_rsp_ready
	);

	sram_model sram_model_inst (
		.clk, .rst, .mem_req, .mem_req_valid, .mem_req_ready,
		.mem_rsp, .mem_rsp_valid, .mem_rsp_ready
	);

endmodule

`default_nettype wire

//--- tb_clock.sv
// Free-running testbench clock, 100 ns period, starts low at time zero
`default_nettype none

module tb_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// Half period
	end

endmodule

`default_nettype wire

//--- core_mem_tb.sv
// Directed tests; memory words are compared only after the testbench has written them
`default_nettype none

module core_mem_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_CYCLES = 16;
	localparam int CLK_NS = 100;
	localparam int DRIVE_NS = 10;	// Inputs change this long after the rising edge
	localparam int DATA_BASE = 512;
	localparam int DATA_WORDS = 8;
	localparam int PROG_WORDS = 96;	// Program region starts at address 0
	localparam int SEQ_PKTS = 16;
	localparam int REDIR_TARGET = 256;
	localparam int REDIR_PKTS = 4;
	localparam int CONT_PKTS = 12;
	localparam int CONT_OPS = 8;
	// Planned bus transactions plus spares for dropped fetches
	localparam int N_TXN = 1 + 3 * DATA_WORDS + PROG_WORDS + SEQ_PKTS + REDIR_PKTS
		+ CONT_PKTS + 2 * CONT_OPS + 4 + 8;
	localparam longint LIMIT_NS = longint'(CLK_NS) * (RST_CYCLES + 40 * N_TXN);

	logic clk;
	logic rst;
	logic fetch_en;
	fetch_pkg::redirect_t redirect;
	logic redirect_valid;
	fetch_pkg::fetch_pkt_t inst_pkt;
	logic inst_valid;
	logic inst_ready;
	fetch_pkg::lsu_req_t lsu_in;
	logic lsu_in_valid;
	logic lsu_in_ready;
	fetch_pkg::mem_rsp_t lsu_out;
	logic lsu_out_valid;
	logic lsu_out_ready;

	logic [fetch_pkg::XLEN-1:0] ref_mem [fetch_pkg::MEM_WORDS];	// Mirror of every store
	logic [fetch_pkg::XLEN-1:0] exp_pc;
	int errors;
	int tests;
	int unsigned seed;

	tb_clock tb_clock_inst (.clk);

	core_mem_top core_mem_top_inst (
		.clk, .rst, .fetch_en, .redirect, .redirect_valid,
		.inst_pkt, .inst_valid, .inst_ready,
		.lsu_in, .lsu_in_valid, .lsu_in_ready,
		.lsu_out, .lsu_out_valid, .lsu_out_ready
	);

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_NS;
	endtask

	task automatic check_value(input string name, input logic [fetch_pkg::XLEN-1:0] got,
			input logic [fetch_pkg::XLEN-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	function automatic int word_index(input logic [fetch_pkg::XLEN-1:0] addr);
		return int'(addr >> 2) % fetch_pkg::MEM_WORDS;
	endfunction

	// Strobed byte lanes take the new data
	function automatic logic [fetch_pkg::XLEN-1:0] merge_lanes(
			input logic [fetch_pkg::XLEN-1:0] old_word, input logic [fetch_pkg::XLEN-1:0] data,
			input logic [3:0] strb);
		logic [fetch_pkg::XLEN-1:0] word;
		word = old_word;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				word[8*b +: 8] = data[8*b +: 8];
		return word;
	endfunction

	task automatic lsu_access(input logic write, input logic [fetch_pkg::XLEN-1:0] addr,
			input logic [fetch_pkg::XLEN-1:0] wdata, input logic [3:0] wstrb,
			output fetch_pkg::mem_rsp_t rsp);
		lsu_in.addr = addr;
		lsu_in.wdata = wdata;
		lsu_in.wstrb = wstrb;
		lsu_in.write = write;
		lsu_in_valid = 1'b1;
		while (!lsu_in_ready)
			next_cycle();
		next_cycle();	// Request taken on this edge
		lsu_in_valid = 1'b0;
		lsu_out_ready = 1'b1;
		while (!lsu_out_valid)
			next_cycle();
		rsp = lsu_out;
		next_cycle();
		lsu_out_ready = 1'b0;
	endtask

	task automatic store_word(input logic [fetch_pkg::XLEN-1:0] addr,
			input logic [fetch_pkg::XLEN-1:0] data, input logic [3:0] strb);
		fetch_pkg::mem_rsp_t rsp;
		lsu_access(1'b1, addr, data, strb, rsp);
		check_value("lsu_out.err", rsp.err, 1'b0);
		check_value("lsu_out.rdata", rsp.rdata, '0);
		ref_mem[word_index(addr)] = merge_lanes(ref_mem[word_index(addr)], data, strb);
	endtask

	task automatic load_word(input logic [fetch_pkg::XLEN-1:0] addr);
		fetch_pkg::mem_rsp_t rsp;
		lsu_access(1'b0, addr, '0, '0, rsp);
		check_value("lsu_out.rdata", rsp.rdata, ref_mem[word_index(addr)]);
		check_value("lsu_out.err", rsp.err, 1'b0);
	endtask

	// Waits for a packet, stalls a random number of cycles, then accepts it
	task automatic take_packet(output fetch_pkg::fetch_pkt_t pkt);
		int gap;
		gap = $urandom % 4;
		while (!inst_valid)
			next_cycle();
		repeat (gap)
			next_cycle();
		pkt = inst_pkt;
		inst_ready = 1'b1;
		next_cycle();
		inst_ready = 1'b0;
	endtask

	task automatic verify_packet(input fetch_pkg::fetch_pkt_t pkt);
		check_value("inst_pkt.pc", pkt.pc, exp_pc);
		check_value("inst_pkt.inst", pkt.inst, ref_mem[word_index(exp_pc)]);
		check_value("inst_pkt.fault", pkt.fault, 1'b0);
		exp_pc = exp_pc + 4;
	endtask

	task automatic pulse_redirect(input logic [fetch_pkg::XLEN-1:0] target);
		redirect.target = target;
		redirect_valid = 1'b1;
		next_cycle();
		redirect_valid = 1'b0;
	endtask

	task automatic reset_and_first_fetch();
		int err0;
		fetch_pkg::fetch_pkt_t pkt;
		err0 = errors;
		repeat (RST_CYCLES) begin
			next_cycle();
			check_value("inst_valid", inst_valid, 1'b0);
			check_value("lsu_out_valid", lsu_out_valid, 1'b0);
		end
		rst = 1'b0;
		fetch_en = 1'b1;
		next_cycle();
		check_value("inst_valid", inst_valid, 1'b0);
		check_value("lsu_out_valid", lsu_out_valid, 1'b0);
		fetch_en = 1'b0;	// First fetch is already out and still completes
		take_packet(pkt);
		check_value("inst_pkt.pc", pkt.pc, fetch_pkg::RESET_PC);
		check_value("inst_pkt.fault", pkt.fault, 1'b0);
		exp_pc = fetch_pkg::RESET_PC + 4;
		report_test("reset", err0);
	endtask

	task automatic write_then_read_back();
		int err0;
		err0 = errors;
		for (int i = 0; i < DATA_WORDS; i++)
			store_word(DATA_BASE + 4 * i, $urandom, 4'hf);
		for (int i = 0; i < DATA_WORDS; i++)
			store_word(DATA_BASE + 4 * i, $urandom, 4'($urandom));	// Partial strobes
		for (int i = 0; i < DATA_WORDS; i++)
			load_word(DATA_BASE + 4 * i + ($urandom % 4));
		report_test("store_load", err0);
	endtask

	task automatic sequential_fetch();
		int err0;
		fetch_pkg::fetch_pkt_t pkt;
		err0 = errors;
		for (int i = 0; i < PROG_WORDS; i++)
			store_word(4 * i, $urandom, 4'hf);
		fetch_en = 1'b1;
		repeat (SEQ_PKTS) begin
			take_packet(pkt);
			verify_packet(pkt);
		end
		report_test("seq_fetch", err0);
	endtask

	task automatic redirect_fetch();
		int err0;
		fetch_pkg::fetch_pkt_t pkt;
		err0 = errors;
		pulse_redirect(REDIR_TARGET);	// Next sequential fetch goes out on this edge
		exp_pc = REDIR_TARGET;
		repeat (REDIR_PKTS) begin
			take_packet(pkt);
			verify_packet(pkt);
		end
		report_test("redirect", err0);
	endtask

	task automatic fetch_under_contention();
		int err0;
		fetch_pkg::fetch_pkt_t pkt;
		err0 = errors;
		fork
			repeat (CONT_PKTS) begin
				take_packet(pkt);
				verify_packet(pkt);
			end
			// Data words already written in full, so partial strobes merge into known bytes
			for (int i = 0; i < CONT_OPS; i++) begin
				store_word(DATA_BASE + 4 * i, $urandom, 4'($urandom | 1));
				load_word(DATA_BASE + 4 * i);
			end
		join
		report_test("contention", err0);
	endtask

	task automatic out_of_range_access();
		int err0;
		fetch_pkg::fetch_pkt_t pkt;
		fetch_pkg::mem_rsp_t rsp;
		err0 = errors;
		store_word(fetch_pkg::MEM_BYTES - 4, $urandom, 4'hf);
		lsu_access(1'b0, fetch_pkg::MEM_BYTES, '0, '0, rsp);
		check_value("lsu_out.err", rsp.err, 1'b1);
		pulse_redirect(fetch_pkg::MEM_BYTES - 4);	// Any held packet is dropped
		exp_pc = fetch_pkg::MEM_BYTES - 4;
		take_packet(pkt);
		verify_packet(pkt);
		while (!inst_valid)
			next_cycle();
		fetch_en = 1'b0;
		take_packet(pkt);
		check_value("inst_pkt.pc", pkt.pc, fetch_pkg::MEM_BYTES);
		check_value("inst_pkt.fault", pkt.fault, 1'b1);
		report_test("out_of_range", err0);
	endtask

	initial begin
		seed = 32'hb142;
		void'($urandom(seed));
		errors = 0;
		tests = 0;
		rst = 1'b1;
		fetch_en = 1'b0;
		redirect = '0;
		redirect_valid = 1'b0;
		inst_ready = 1'b0;
		lsu_in = '0;
		lsu_in_valid = 1'b0;
		lsu_out_ready = 1'b0;
		reset_and_first_fetch();
		write_then_read_back();
		sequential_fetch();
		redirect_fetch();
		fetch_under_contention();
		out_of_range_access();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_NS);
		$display("Timeout: the tests did not complete within %0d ns", LIMIT_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
fetch_pkg.sv
ifu.sv
lsu.sv
mem_arbiter.sv
sram_model.sv
core_mem_top.sv
tb_clock.sv
core_mem_tb.sv
